/* src.f */
logic/fpuPkg.sv
logic/fpuStageIf.sv
logic/fpuMulArray.sv
logic/fpuProductSum.sv
logic/fpuNormRound.sv
logic/fpuMulUnit.sv
verification/fpuMulChecker.sv
verification/fpuMulTb.sv

/* Makefile */
# Verilator build and run of the double multiplier testbench
# override on the command line, e.g. make sim SEED=12345 LOG=run.log

VERILATOR ?= verilator
TOP ?= fpuMulTb
LOG ?= sim.log
SEED ?= 303061518
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GrandomSeed=$(SEED) \
		-f src.f --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/fpuMulTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the pipelined double multiplier
// runs random and directed blocks with random stalls, prints one line per
// test and a closing summary; the scoreboard does the comparing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuMulTb import fpuPkg::*; #(
	parameter int unsigned randomSeed = 32'h1210_5a0e
) ();

	localparam int DRAIN_LIMIT = 100;
	localparam int ISSUE_TRIES = 32;

	logic clock;
	logic rstN;
	logic hold;
	logic opValid;
	logic [FPU_WIDTH-1:0] opA;
	logic [FPU_WIDTH-1:0] opB;
	roundModeT roundMode;
	logic ieeeMode;
	logic resValid;
	logic [FPU_WIDTH-1:0] result;
	mulFlagsT flags;

	int checkCount;
	int errorCount;
	int pendingCount;
	int tbErrors;
	logic aborted;

	fpuMulUnit #(
		.expBias(EXP_BIAS),
		.expMax(EXP_MAX)
	) UUT (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.roundMode(roundMode),
		.ieeeMode(ieeeMode),
		.resValid(resValid),
		.result(result),
		.flags(flags)
	);

	fpuMulChecker scoreboard (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.roundMode(roundMode),
		.ieeeMode(ieeeMode),
		.resValid(resValid),
		.result(result),
		.flags(flags),
		.checkCount(checkCount),
		.errorCount(errorCount),
		.pendingCount(pendingCount)
	);

	// 8 ns period
	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// random sign and fraction, exponent in range
	function automatic logic [FPU_WIDTH-1:0] randOperand(input int expLo, input int expHi);
		logic [FPU_WIDTH-1:0] v;
		v[63] = 1'($urandom_range(1, 0));
		v[62:52] = 11'($urandom_range(expHi, expLo));
		v[51:32] = 20'($urandom);
		v[31:0] = $urandom;
		return v;
	endfunction

	// kind 0 zero, kind 1 subnormal, else normal
	function automatic logic [FPU_WIDTH-1:0] specialOperand(input int kind);
		logic [FPU_WIDTH-1:0] v;
		v = randOperand(1, 2046);
		if (kind == 0)
			v[62:0] = '0;
		else if (kind == 1)
		begin
			v[62:52] = '0;
			v[0] = 1'b1;
		end
		return v;
	endfunction

	function automatic roundModeT randMode(input int lo);
		return roundModeT'(2'($urandom_range(3, lo)));
	endfunction

	// present one operation, stalling randomly first
	task automatic issueOp(
		input logic [FPU_WIDTH-1:0] a,
		input logic [FPU_WIDTH-1:0] b,
		input roundModeT mode,
		input logic ieee,
		input int holdPct
	);
		int tries;
		logic placed;
		tries = 0;
		placed = 1'b0;
		while (!placed)
		begin
			@(posedge clock);
			#1;
			tries++;
			if (tries < ISSUE_TRIES && $urandom_range(99, 0) < holdPct)
			begin
				hold = 1'b1;
				opValid = 1'b0;
			end
			else
			begin
				hold = 1'b0;
				opValid = 1'b1;
				opA = a;
				opB = b;
				roundMode = mode;
				ieeeMode = ieee;
				placed = 1'b1;
			end
		end
	endtask

	// stop issuing, wait for the queue to empty, report the test
	task automatic drainPipe(input string testName, input int startChecks, input int startErrors);
		int waited;
		waited = 0;
		@(posedge clock);
		#1;
		hold = 1'b0;
		opValid = 1'b0;
		while (pendingCount != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clock);
			waited++;
		end
		if (pendingCount != 0)
		begin
			$display("test %s: pipeline did not drain, %0d results never appeared",
				testName, pendingCount);
			aborted = 1'b1;
		end
		else
			$display("test %-20s %4d results checked, %0d errors", testName,
				checkCount - startChecks, errorCount + tbErrors - startErrors);
	endtask

	task automatic checkResetState();
		int startErrors;
		startErrors = tbErrors;
		repeat (4)
		begin
			@(negedge clock);
			if (resValid !== 1'b0 || flags !== '0)
			begin
				tbErrors++;
				$display("** Error at %0t: resValid %b flags %b after reset, expected zero",
					$time, resValid, flags);
			end
		end
		$display("test %-20s %4d results checked, %0d errors", "resetState", 0,
			tbErrors - startErrors);
	endtask

	task automatic runNearestRandom();
		int c0;
		int e0;
		c0 = checkCount;
		e0 = errorCount + tbErrors;
		// back to back, four in flight
		repeat (300)
			issueOp(randOperand(600, 1400), randOperand(600, 1400), roundNearest,
				1'($urandom_range(1, 0)), 0);
		drainPipe("nearestRandom", c0, e0);
	endtask

	task automatic runDirectedRounding();
		logic [51:0] fracA [4];
		logic [51:0] fracB [4];
		int c0;
		int e0;
		c0 = checkCount;
		e0 = errorCount + tbErrors;
		// kept bits all ones, round bit set, carries into the exponent
		fracA[0] = 52'h5555555555555;
		fracB[0] = 52'h8000000000000;
		// all-ones fractions, sticky only
		fracA[1] = '1;
		fracB[1] = '1;
		// exact
		fracA[2] = '1;
		fracB[2] = '0;
		fracA[3] = 52'h0000000000001;
		fracB[3] = '1;
		for (int m = 0; m < 4; m++)
			for (int s = 0; s < 4; s++)
				for (int k = 0; k < 4; k++)
					issueOp({s[1], 11'd1023, fracA[k]}, {s[0], 11'd1000, fracB[k]},
						roundModeT'(2'(m)), 1'b0, 0);
		repeat (120)
			issueOp(randOperand(700, 1300), randOperand(700, 1300), randMode(1), 1'b0, 0);
		drainPipe("directedRounding", c0, e0);
	endtask

	task automatic runRangeLimits();
		int c0;
		int e0;
		c0 = checkCount;
		e0 = errorCount + tbErrors;
		for (int i = 0; i < 80; i++)
		begin
			case (i % 4)
				0: issueOp(randOperand(1600, 2046), randOperand(1600, 2046), randMode(0), 1'b0, 0);
				1: issueOp(randOperand(1, 400), randOperand(1, 400), randMode(0), 1'b0, 0);
				// one step from overflow
				2: issueOp(randOperand(1023, 1023), randOperand(2045, 2046), randMode(0), 1'b0, 0);
				// one step from flush
				default: issueOp(randOperand(1, 1), randOperand(1021, 1022), randMode(0), 1'b0, 0);
			endcase
		end
		drainPipe("rangeLimits", c0, e0);
	endtask

	task automatic runZeroSubnormal();
		logic [FPU_WIDTH-1:0] a;
		logic [FPU_WIDTH-1:0] b;
		int c0;
		int e0;
		c0 = checkCount;
		e0 = errorCount + tbErrors;
		repeat (80)
		begin
			a = specialOperand(int'($urandom_range(1, 0)));
			b = specialOperand(int'($urandom_range(2, 0)));
			if ($urandom_range(1, 0) == 1)
				issueOp(b, a, randMode(0), 1'($urandom_range(1, 0)), 10);
			else
				issueOp(a, b, randMode(0), 1'($urandom_range(1, 0)), 10);
		end
		drainPipe("zeroSubnormal", c0, e0);
	endtask

	task automatic runHoldTraffic();
		int c0;
		int e0;
		c0 = checkCount;
		e0 = errorCount + tbErrors;
		repeat (400)
			issueOp(randOperand(300, 1750), randOperand(300, 1750), randMode(0),
				1'($urandom_range(1, 0)), 35);
		drainPipe("holdTraffic", c0, e0);
	endtask

	initial
	begin
		void'($urandom(randomSeed));
		rstN = 1'b0;
		hold = 1'b0;
		opValid = 1'b0;
		opA = '0;
		opB = '0;
		roundMode = roundNearest;
		ieeeMode = 1'b0;
		tbErrors = 0;
		aborted = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		rstN = 1'b1;
		checkResetState();
		runNearestRandom();
		if (!aborted)
			runDirectedRounding();
		if (!aborted)
			runRangeLimits();
		if (!aborted)
			runZeroSubnormal();
		if (!aborted)
			runHoldTraffic();
		if (pendingCount != 0)
			$display("%0d expected results were left unmatched at the end", pendingCount);
		$display("summary: %0d results checked, %0d errors, %0d left in queue",
			checkCount, errorCount + tbErrors, pendingCount);
		if (!aborted && errorCount + tbErrors == 0 && pendingCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verification/fpuMulChecker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scoreboard for the double multiplier
// expected results are queued at every accepted opValid and are compared in
// order with each resValid; counts are exported to the testbench top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuMulChecker import fpuPkg::*; (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic opValid,
	input logic [FPU_WIDTH-1:0] opA,
	input logic [FPU_WIDTH-1:0] opB,
	input roundModeT roundMode,
	input logic ieeeMode,
	input logic resValid,
	input logic [FPU_WIDTH-1:0] result,
	input mulFlagsT flags,
	output int checkCount,
	output int errorCount,
	output int pendingCount
);

	// one outstanding operation and what it must return
	typedef struct packed {
		logic [FPU_WIDTH-1:0] a;
		logic [FPU_WIDTH-1:0] b;
		roundModeT mode;
		logic [FPU_WIDTH-1:0] result;
		mulFlagsT flags;
	} expectT;

	expectT expectQ [$];
	expectT head;

	// binary64 product with flush-to-zero and saturation
	function automatic expectT refMultiply(
		input logic [FPU_WIDTH-1:0] a,
		input logic [FPU_WIDTH-1:0] b,
		input roundModeT mode,
		input logic ieee
	);
		expectT e;
		logic sign;
		int expA;
		int expB;
		int expRes;
		logic [PROD_WIDTH-1:0] full;
		logic [52:0] kept;
		logic [53:0] bumped;
		logic roundBit;
		logic stickyBit;
		logic bump;
		sign = a[63] ^ b[63];
		expA = int'(a[62:52]);
		expB = int'(b[62:52]);
		e.a = a;
		e.b = b;
		e.mode = mode;
		e.flags.fault = ieee && ((expA == 0 && a[51:0] != '0) || (expB == 0 && b[51:0] != '0));
		e.flags.inexact = 1'b0;
		e.result = {sign, 63'd0};
		// exponent zero means zero, exact
		if (expA == 0 || expB == 0)
			return e;
		full = PROD_WIDTH'({1'b1, a[51:0]}) * PROD_WIDTH'({1'b1, b[51:0]});
		expRes = expA + expB - EXP_BIAS;
		if (full[105])
		begin
			expRes++;
			kept = full[105:53];
			roundBit = full[52];
			stickyBit = |full[51:0];
		end
		else
		begin
			kept = full[104:52];
			roundBit = full[51];
			stickyBit = |full[50:0];
		end
		case (mode)
			roundNearest: bump = roundBit;
			roundTrunc: bump = 1'b0;
			roundPlusInf: bump = !sign && (roundBit || stickyBit);
			default: bump = sign && (roundBit || stickyBit);
		endcase
		bumped = {1'b0, kept} + 54'(bump);
		// significand overflow, renormalize
		if (bumped[53])
		begin
			kept = bumped[53:1];
			expRes++;
		end
		else
			kept = bumped[52:0];
		if (expRes >= EXP_MAX)
		begin
			e.result = {sign, 11'h7ff, 52'd0};
			e.flags.inexact = 1'b1;
		end
		else if (expRes <= 0)
			e.flags.inexact = 1'b1;
		else
		begin
			e.result = {sign, 11'(expRes), kept[51:0]};
			e.flags.inexact = roundBit || stickyBit;
		end
		return e;
	endfunction

	// mid-cycle sampling, inputs and outputs settled
	always @(negedge clock)
	begin
		if (!rstN)
		begin
			expectQ.delete();
			checkCount = 0;
			errorCount = 0;
		end
		else
		begin
			if (hold && resValid)
			begin
				errorCount++;
				$display("resValid was raised during a held cycle at %0t", $time);
			end
			if (!hold && resValid)
			begin
				if (expectQ.size() == 0)
				begin
					errorCount++;
					$display("a result appeared at %0t with no operation outstanding", $time);
				end
				else
				begin
					head = expectQ.pop_front();
					checkCount++;
					if (result !== head.result || flags !== head.flags)
					begin
						errorCount++;
						$display("** Error at %0t: a=%h b=%h mode=%0d got %h flags %b, expected %h flags %b",
							$time, head.a, head.b, head.mode, result, flags,
							head.result, head.flags);
					end
				end
			end
			if (!hold && opValid)
				expectQ.push_back(refMultiply(opA, opB, roundMode, ieeeMode));
		end
		pendingCount = expectQ.size();
	end

endmodule

/* logic/fpuMulUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined binary64 multiplier, four cycles from opValid to resValid
// hold stalls every stage; no work may be presented while it is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuMulUnit import fpuPkg::*; #(
	parameter int expBias = EXP_BIAS,
	parameter int expMax = EXP_MAX
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic opValid,
	input logic [FPU_WIDTH-1:0] opA,
	input logic [FPU_WIDTH-1:0] opB,
	input roundModeT roundMode,
	input logic ieeeMode,
	output logic resValid,
	output logic [FPU_WIDTH-1:0] result,
	output mulFlagsT flags
);

	// carry-save pair, stage 2 to 3
	fpuStageIf #(.payloadT(csPairT)) csLink ();
	// resolved product, stage 3 to 4
	fpuStageIf #(.payloadT(productT)) prodLink ();

	fpuMulArray #(
		.expBias(expBias)
	) mulArray (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.opValid(opValid),
		.opA(opA),
		.opB(opB),
		.roundMode(roundMode),
		.ieeeMode(ieeeMode),
		.cs(csLink.producer)
	);

	fpuProductSum productSum (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.cs(csLink.consumer),
		.prod(prodLink.producer)
	);

	fpuNormRound #(
		.expMax(expMax)
	) normRound (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.prod(prodLink.consumer),
		.resValid(resValid),
		.result(result),
		.flags(flags)
	);

endmodule

/* logic/fpuNormRound.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// last multiplier stage that normalizes, rounds, saturates and flags
// result and flags registered at edge 4 and resValid kept low on held cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuNormRound import fpuPkg::*; #(
	parameter int expMax = EXP_MAX
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	fpuStageIf.consumer prod,
	output logic resValid,
	output logic [FPU_WIDTH-1:0] result,
	output mulFlagsT flags
);

	localparam int MANT_WIDTH = FRAC_WIDTH + 1;

	logic [PROD_WIDTH-1:0] p;
	logic topBit;
	logic [MANT_WIDTH-1:0] mant;
	logic roundBit;
	logic stickyBit;
	logic increment;
	logic [MANT_WIDTH:0] mantSum;
	logic [MANT_WIDTH-1:0] mantFinal;
	logic signed [EXP_WIDTH+1:0] expNorm;
	logic signed [EXP_WIDTH+1:0] expFinal;
	logic [FPU_WIDTH-1:0] resultNext;
	mulFlagsT flagsNext;
	logic outValid;

	assign p = prod.payload.product;
	assign topBit = p[PROD_WIDTH-1];

	// leading one at bit 105 or 104
	always_comb
	begin
		if (topBit)
		begin
			mant = p[PROD_WIDTH-1 -: MANT_WIDTH];
			roundBit = p[PROD_WIDTH-1-MANT_WIDTH];
			stickyBit = |p[PROD_WIDTH-2-MANT_WIDTH:0];
		end
		else
		begin
			mant = p[PROD_WIDTH-2 -: MANT_WIDTH];
			roundBit = p[PROD_WIDTH-2-MANT_WIDTH];
			stickyBit = |p[PROD_WIDTH-3-MANT_WIDTH:0];
		end
		expNorm = prod.ctl.exponent + (EXP_WIDTH+2)'(topBit);
	end

	// increment decision per mode
	always_comb
	begin
		case (prod.ctl.roundMode)
			roundNearest: increment = roundBit;
			roundTrunc: increment = 1'b0;
			roundPlusInf: increment = !prod.ctl.sign && (roundBit || stickyBit);
			roundMinusInf: increment = prod.ctl.sign && (roundBit || stickyBit);
			default: increment = 1'b0;
		endcase
	end

	// carry out of the significand bumps the exponent
	assign mantSum = {1'b0, mant} + (MANT_WIDTH+1)'(increment);

	always_comb
	begin
		if (mantSum[MANT_WIDTH])
		begin
			mantFinal = mantSum[MANT_WIDTH:1];
			expFinal = expNorm + (EXP_WIDTH+2)'(1);
		end
		else
		begin
			mantFinal = mantSum[MANT_WIDTH-1:0];
			expFinal = expNorm;
		end
	end

	always_comb
	begin
		flagsNext.fault = prod.ctl.ieeeMode && prod.ctl.subnormalSeen;
		if (p[PROD_WIDTH-1 -: 2] == 2'b00)
		begin
			// zero operand gives an exact signed zero
			resultNext = {prod.ctl.sign, {(FPU_WIDTH-1){1'b0}}};
			flagsNext.inexact = 1'b0;
		end
		else if (expFinal >= $signed((EXP_WIDTH+2)'(expMax)))
		begin
			// overflow saturates to infinity
			resultNext = {prod.ctl.sign, {EXP_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
			flagsNext.inexact = 1'b1;
		end
		else if (expFinal <= 0)
		begin
			// no gradual underflow so flush to zero
			resultNext = {prod.ctl.sign, {(FPU_WIDTH-1){1'b0}}};
			flagsNext.inexact = 1'b1;
		end
		else
		begin
			resultNext = {prod.ctl.sign, expFinal[EXP_WIDTH-1:0],
				mantFinal[FRAC_WIDTH-1:0]};
			flagsNext.inexact = roundBit || stickyBit;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			flags <= '0;
		end
		else if (!hold)
		begin
			outValid <= prod.valid;
			flags <= flagsNext;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			result <= resultNext;
	end

	// a held result is shown on the first free cycle only
	assign resValid = outValid && !hold;

	// a product below bit 104 can only be the forced zero of a zero operand
	productNormal: assert property (@(posedge clock) disable iff (!rstN)
		prod.valid && (p[PROD_WIDTH-1 -: 2] == 2'b00) |-> (p == '0));

endmodule

/* logic/fpuProductSum.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// third multiplier stage, resolves the carry-save pair to one product
// carry-select adder over two 53-bit halves, registered at edge 3
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuProductSum import fpuPkg::*; (
	input logic clock,
	input logic rstN,
	input logic hold,
	fpuStageIf.consumer cs,
	fpuStageIf.producer prod
);

	localparam int HALF = PROD_WIDTH / 2;

	logic [HALF:0] loSum;
	logic [HALF:0] hiSum0;
	logic [HALF:0] hiSum1;
	logic [HALF:0] hiSel;
	logic carryOut;
	productT prodNext;

	// low half, its carry picks the upper result
	assign loSum = {1'b0, cs.payload.sumA[HALF-1:0]}
		+ {1'b0, cs.payload.sumB[HALF-1:0]};

	// upper half for both carry-in values
	assign hiSum0 = {1'b0, cs.payload.sumA[PROD_WIDTH-1:HALF]}
		+ {1'b0, cs.payload.sumB[PROD_WIDTH-1:HALF]};
	assign hiSum1 = {1'b0, cs.payload.sumA[PROD_WIDTH-1:HALF]}
		+ {1'b0, cs.payload.sumB[PROD_WIDTH-1:HALF]} + (HALF+1)'(1);

	assign hiSel = loSum[HALF] ? hiSum1 : hiSum0;
	assign carryOut = hiSel[HALF];
	assign prodNext.product = {hiSel[HALF-1:0], loSum[HALF-1:0]};

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			prod.valid <= 1'b0;
		else if (!hold)
			prod.valid <= cs.valid;
	end

	// control fields pass through unchanged
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			prod.ctl <= cs.ctl;
			prod.payload <= prodNext;
		end
	end

	// the CSA tree upstream never loses a carry, so the sum fits
	productFits: assert property (@(posedge clock) disable iff (!rstN)
		cs.valid && !hold |-> !carryOut);

endmodule

/* logic/fpuMulArray.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first two multiplier stages with operand unpack, slice products and CSA tree
// edge 1 holds the nine slice products and edge 2 the carry-save pair
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fpuMulArray import fpuPkg::*; #(
	parameter int expBias = EXP_BIAS
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic opValid,
	input logic [FPU_WIDTH-1:0] opA,
	input logic [FPU_WIDTH-1:0] opB,
	input roundModeT roundMode,
	input logic ieeeMode,
	fpuStageIf.producer cs
);

	// 53-bit significand padded to three full slices
	localparam int NUM_SLICES = 3;
	localparam int SIG_WIDTH = NUM_SLICES * SLICE_WIDTH;
	localparam int PP_WIDTH = 2 * SLICE_WIDTH;

	logic [EXP_WIDTH-1:0] expA;
	logic [EXP_WIDTH-1:0] expB;
	logic [FRAC_WIDTH-1:0] fracA;
	logic [FRAC_WIDTH-1:0] fracB;
	logic [SIG_WIDTH-1:0] sigA;
	logic [SIG_WIDTH-1:0] sigB;
	logic [PP_WIDTH-1:0] ppNext [NUM_SLICES][NUM_SLICES];
	stageCtlT ctlNext;
	logic zeroNext;

	// stage 1 registers
	logic s1Valid;
	stageCtlT s1Ctl;
	logic s1Zero;
	logic [PP_WIDTH-1:0] s1Pp [NUM_SLICES][NUM_SLICES];

	// stage 2 compressor tree
	logic [PROD_WIDTH-1:0] terms [NUM_SLICES*NUM_SLICES];
	csPairT lvl1 [NUM_SLICES];
	csPairT lvl2 [2];
	csPairT lvl3;
	csPairT csNext;

	// 3:2 compressor over full product width
	function automatic csPairT csa3(
		input logic [PROD_WIDTH-1:0] a,
		input logic [PROD_WIDTH-1:0] b,
		input logic [PROD_WIDTH-1:0] c
	);
		csPairT r;
		r.sumA = a ^ b ^ c;
		// carries weigh one bit higher
		r.sumB = ((a & b) | (a & c) | (b & c)) << 1;
		return r;
	endfunction

	assign expA = opA[FPU_WIDTH-2 -: EXP_WIDTH];
	assign expB = opB[FPU_WIDTH-2 -: EXP_WIDTH];
	assign fracA = opA[FRAC_WIDTH-1:0];
	assign fracB = opB[FRAC_WIDTH-1:0];

	// hidden one attached and top pad bit left zero
	assign sigA = {1'b0, 1'b1, fracA};
	assign sigB = {1'b0, 1'b1, fracB};

	always_comb
	begin
		for (int i = 0; i < NUM_SLICES; i++)
		begin
			for (int j = 0; j < NUM_SLICES; j++)
			begin
				ppNext[i][j] = PP_WIDTH'(sigA[i*SLICE_WIDTH +: SLICE_WIDTH])
					* PP_WIDTH'(sigB[j*SLICE_WIDTH +: SLICE_WIDTH]);
			end
		end
	end

	// sign, biased exponent and input classification
	always_comb
	begin
		ctlNext.sign = opA[FPU_WIDTH-1] ^ opB[FPU_WIDTH-1];
		ctlNext.exponent = (EXP_WIDTH+2)'(expA) + (EXP_WIDTH+2)'(expB)
			- (EXP_WIDTH+2)'(expBias);
		ctlNext.subnormalSeen = ((expA == '0) && (fracA != '0))
			|| ((expB == '0) && (fracB != '0));
		ctlNext.roundMode = roundMode;
		ctlNext.ieeeMode = ieeeMode;
		// any exponent-zero input counts as zero
		zeroNext = (expA == '0) || (expB == '0);
	end

	// stage 1 valid
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			s1Valid <= 1'b0;
		else if (!hold)
			s1Valid <= opValid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			s1Ctl <= ctlNext;
			s1Zero <= zeroNext;
			s1Pp <= ppNext;
		end
	end

	// align slice products by their weight
	always_comb
	begin
		for (int i = 0; i < NUM_SLICES; i++)
		begin
			for (int j = 0; j < NUM_SLICES; j++)
			begin
				terms[i*NUM_SLICES+j] = PROD_WIDTH'(s1Pp[i][j])
					<< (SLICE_WIDTH*(i+j));
			end
		end
	end

	// nine words down to two
	always_comb
	begin
		for (int k = 0; k < NUM_SLICES; k++)
		begin
			lvl1[k] = csa3(terms[3*k], terms[3*k+1], terms[3*k+2]);
		end
		lvl2[0] = csa3(lvl1[0].sumA, lvl1[0].sumB, lvl1[1].sumA);
		lvl2[1] = csa3(lvl1[1].sumB, lvl1[2].sumA, lvl1[2].sumB);
		lvl3 = csa3(lvl2[0].sumA, lvl2[0].sumB, lvl2[1].sumA);
		csNext = csa3(lvl3.sumA, lvl3.sumB, lvl2[1].sumB);
		// zero operand gives a zero product downstream
		if (s1Zero)
			csNext = '0;
	end

	// stage 2 valid
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			cs.valid <= 1'b0;
		else if (!hold)
			cs.valid <= s1Valid;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			cs.ctl <= s1Ctl;
			cs.payload <= csNext;
		end
	end

	// work offered during a stall would never be captured
	noIssueWhileHeld: assert property (@(posedge clock) disable iff (!rstN)
		hold |-> !opValid);

endmodule

/* logic/fpuStageIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link between two multiplier stages
// payload type is chosen per link, control fields are common to all links
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface fpuStageIf import fpuPkg::*; #(
	parameter type payloadT = logic
) ();

	// item present in the upstream output register
	logic valid;
	stageCtlT ctl;
	payloadT payload;

	// upstream stage owns the registers
	modport producer (
		output valid,
		output ctl,
		output payload
	);

	modport consumer (
		input valid,
		input ctl,
		input payload
	);

endinterface

/* logic/fpuPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, encodings and stage payloads of the double multiplier
// imported by every stage and by the stage interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fpuPkg;

	// binary64 field layout
	localparam int FPU_WIDTH = 64;
	localparam int EXP_WIDTH = 11;
	localparam int FRAC_WIDTH = 52;

	// exponent encoding
	localparam int EXP_BIAS = 1023;
	localparam int EXP_MAX = 2047;

	// full significand product, 53 x 53 bits
	localparam int PROD_WIDTH = 106;

	// multiplier slice, matches an 18x18 DSP block
	localparam int SLICE_WIDTH = 18;

	// rounding mode as presented with the operands
	typedef enum logic [1:0] {
		roundNearest = 2'd0,
		roundTrunc = 2'd1,
		roundPlusInf = 2'd2,
		roundMinusInf = 2'd3
	} roundModeT;

	// status bits returned with the product
	typedef struct packed {
		logic inexact;
		logic fault;
	} mulFlagsT;

	// redundant product, value is sumA + sumB
	typedef struct packed {
		logic [PROD_WIDTH-1:0] sumA;
		logic [PROD_WIDTH-1:0] sumB;
	} csPairT;

	// resolved product of the two significands
	typedef struct packed {
		logic [PROD_WIDTH-1:0] product;
	} productT;

	// control fields riding along with every item
	typedef struct packed {
		logic sign;
		// biased sum, two extra bits for overflow and negative range
		logic signed [EXP_WIDTH+1:0] exponent;
		// an input had exponent zero and a nonzero fraction
		logic subnormalSeen;
		roundModeT roundMode;
		logic ieeeMode;
	} stageCtlT;

endpackage
